//--- files.f
common/rvPkg.sv
datapath/regFile.sv
datapath/immExtend.sv
datapath/alu.sv
datapath/multicycleDatapath.sv
control/controlFsm.sv
control/aluDecoder.sv
src/rvCore.sv
verif/coreTb.sv

//--- verif/coreTb.sv
// ####################
// testbench for the multicycle RV32I core
// memory model, clock, reset and directed tests
// ####################

`timescale 1ns/100ps

module coreTb;

	localparam logic [6:0] opLogic = 7'b0010011;
	localparam logic [6:0] opLoad  = 7'b0000011;
	// jal x0, 0 spins in place
	localparam logic [31:0] haltWord = 32'h0000006f;

	logic        clk;
	logic        reset;
	logic [31:0] memReadData;
	logic [31:0] memAddr;
	logic [31:0] memWriteData;
	logic        memWrite;

	logic [31:0] mem [0:255];
	logic [31:0] lastStoreAddr;
	logic [31:0] lastStoreData;
	logic [31:0] storeAddrLog [0:63];
	logic [31:0] storeDataLog [0:63];
	integer      storeCount = 0;
	integer      storeStart;
	integer      errStart;
	integer      progIndex;
	integer      seed;
	integer      testCount;
	integer      checkCount;
	integer      errorCount;

	rvCore dut (
		.clk          (clk),
		.reset        (reset),
		.memReadData  (memReadData),
		.memAddr      (memAddr),
		.memWriteData (memWriteData),
		.memWrite     (memWrite)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// word-addressed, read answers in the same cycle
	assign memReadData = mem[memAddr[9:2]];

	always @(posedge clk) begin
		if (memWrite === 1'b1) begin
			mem[memAddr[9:2]]             <= memWriteData;
			lastStoreAddr                 <= memAddr;
			lastStoreData                 <= memWriteData;
			storeAddrLog[storeCount[5:0]] <= memAddr;
			storeDataLog[storeCount[5:0]] <= memWriteData;
			storeCount                    <= storeCount + 1;
		end
	end

	function automatic logic [31:0] signExtend12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encodeI(input logic [6:0] op, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encodeS(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// beq only, offset in bytes
	function automatic logic [31:0] encodeB(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encodeJ(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic clearMemory;
		integer i;
		for (i = 0; i < 256; i = i + 1) begin
			mem[i] <= 32'h0;
		end
	endtask

	task automatic putInstr(input logic [31:0] word);
		mem[progIndex] <= word;
		progIndex = progIndex + 1;
	endtask

	// core held in reset while the new program goes in
	task automatic beginTest;
		@(posedge clk);
		#1;
		reset = 1'b1;
		clearMemory();
		progIndex  = 0;
		errStart   = errorCount;
		storeStart = storeCount;
	endtask

	task automatic releaseReset;
		repeat (3) begin
			@(posedge clk);
			#1;
		end
		reset = 1'b0;
	endtask

	task automatic waitStores(input integer n, input string name);
		integer cycles;
		cycles = 0;
		while ((storeCount - storeStart) < n && cycles < 300) begin
			@(posedge clk);
			#1;
			cycles = cycles + 1;
		end
		if ((storeCount - storeStart) < n) begin
			$display("%s: timed out after %0d cycles, saw %0d of %0d stores", name, cycles,
				storeCount - storeStart, n);
			errorCount = errorCount + 1;
		end
	endtask

	task automatic compareWord(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount = checkCount + 1;
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", what, expected, actual);
			errorCount = errorCount + 1;
		end
	endtask

	// k counts the stores of the current test from zero
	task automatic checkStore(input string name, input integer k, input logic [31:0] expAddr,
			input logic [31:0] expData);
		compareWord({name, " address"}, expAddr, storeAddrLog[storeStart + k]);
		compareWord({name, " data"}, expData, storeDataLog[storeStart + k]);
	endtask

	task automatic endTest(input string name);
		testCount = testCount + 1;
		if (errorCount == errStart) begin
			$display("%s passed", name);
		end else begin
			$display("%s failed with %0d errors", name, errorCount - errStart);
		end
	endtask

	task automatic resetTest;
		beginTest();
		putInstr(encodeI(opLogic, 3'b000, 5'd1, 5'd0, 12'h123));
		putInstr(encodeS(5'd1, 5'd0, 12'h040));
		putInstr(haltWord);
		releaseReset();
		compareWord("reset memAddr", 32'h0, memAddr);
		compareWord("reset memWrite", 32'h0, {31'b0, memWrite});
		waitStores(1, "reset");
		compareWord("reset first store address", 32'h40, lastStoreAddr);
		compareWord("reset first store data", 32'h123, lastStoreData);
		endTest("reset");
	endtask

	task automatic rTypeTest;
		logic [31:0] rnd;
		logic [31:0] valA;
		logic [31:0] valB;
		beginTest();
		rnd  = $random(seed);
		// bit 10 set, so the addi word carries funct7 bit 5
		valA = signExtend12(rnd[11:0] | 12'h400);
		rnd  = $random(seed);
		valB = signExtend12(rnd[11:0]);
		putInstr(encodeI(opLogic, 3'b000, 5'd1, 5'd0, valA[11:0]));
		putInstr(encodeI(opLogic, 3'b000, 5'd2, 5'd0, valB[11:0]));
		// x1 stored as is, a sub decode of addi would show here
		putInstr(encodeS(5'd1, 5'd0, 12'h114));
		putInstr(encodeR(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
		putInstr(encodeS(5'd3, 5'd0, 12'h100));
		putInstr(encodeR(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
		putInstr(encodeS(5'd4, 5'd0, 12'h104));
		putInstr(encodeR(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
		putInstr(encodeS(5'd5, 5'd0, 12'h108));
		putInstr(encodeR(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
		putInstr(encodeS(5'd6, 5'd0, 12'h10c));
		putInstr(encodeR(7'h00, 3'b010, 5'd7, 5'd1, 5'd2));
		putInstr(encodeS(5'd7, 5'd0, 12'h110));
		putInstr(haltWord);
		releaseReset();
		waitStores(6, "rtype");
		checkStore("rtype addi", 0, 32'h114, valA);
		checkStore("rtype add", 1, 32'h100, valA + valB);
		checkStore("rtype sub", 2, 32'h104, valA - valB);
		checkStore("rtype and", 3, 32'h108, valA & valB);
		checkStore("rtype or", 4, 32'h10c, valA | valB);
		checkStore("rtype slt", 5, 32'h110, ($signed(valA) < $signed(valB)) ? 32'd1 : 32'd0);
		endTest("rtype");
	endtask

	task automatic iTypeTest;
		logic [31:0] rnd;
		logic [31:0] valA;
		logic [31:0] valN;
		beginTest();
		rnd  = $random(seed);
		valA = signExtend12(rnd[11:0]);
		rnd  = $random(seed);
		// top bit forced so the immediate is negative
		valN = signExtend12(rnd[11:0] | 12'h800);
		putInstr(encodeI(opLogic, 3'b000, 5'd1, 5'd0, valA[11:0]));
		putInstr(encodeI(opLogic, 3'b111, 5'd2, 5'd1, valN[11:0]));
		putInstr(encodeS(5'd2, 5'd0, 12'h100));
		putInstr(encodeI(opLogic, 3'b110, 5'd3, 5'd1, valN[11:0]));
		putInstr(encodeS(5'd3, 5'd0, 12'h104));
		putInstr(encodeI(opLogic, 3'b010, 5'd4, 5'd1, valN[11:0]));
		putInstr(encodeS(5'd4, 5'd0, 12'h108));
		putInstr(haltWord);
		releaseReset();
		waitStores(3, "itype");
		checkStore("itype andi", 0, 32'h100, valA & valN);
		checkStore("itype ori", 1, 32'h104, valA | valN);
		checkStore("itype slti", 2, 32'h108, ($signed(valA) < $signed(valN)) ? 32'd1 : 32'd0);
		endTest("itype");
	endtask

	task automatic loadStoreTest;
		logic [31:0] word;
		beginTest();
		word = $random(seed);
		// data word at 0x200
		mem[128] <= word;
		putInstr(encodeI(opLogic, 3'b000, 5'd5, 5'd0, 12'h180));
		putInstr(encodeI(opLoad, 3'b010, 5'd1, 5'd5, 12'h080));
		putInstr(encodeS(5'd1, 5'd5, 12'h000));
		putInstr(encodeI(opLoad, 3'b010, 5'd2, 5'd5, 12'h000));
		putInstr(encodeI(opLogic, 3'b000, 5'd4, 5'd2, 12'h001));
		putInstr(encodeS(5'd4, 5'd5, 12'hff8));
		putInstr(haltWord);
		releaseReset();
		waitStores(2, "loadstore");
		checkStore("loadstore first sw", 0, 32'h180, word);
		checkStore("loadstore second sw", 1, 32'h178, word + 32'd1);
		endTest("loadstore");
	endtask

	task automatic branchTest;
		beginTest();
		putInstr(encodeI(opLogic, 3'b000, 5'd1, 5'd0, 12'd7));
		putInstr(encodeI(opLogic, 3'b000, 5'd2, 5'd0, 12'd7));
		putInstr(encodeI(opLogic, 3'b000, 5'd3, 5'd0, 12'd1));
		// taken, jumps over the next store
		putInstr(encodeB(5'd1, 5'd2, 13'd8));
		putInstr(encodeS(5'd3, 5'd0, 12'h100));
		putInstr(encodeI(opLogic, 3'b000, 5'd3, 5'd0, 12'd2));
		putInstr(encodeS(5'd3, 5'd0, 12'h104));
		putInstr(encodeI(opLogic, 3'b000, 5'd3, 5'd0, 12'd3));
		putInstr(encodeB(5'd1, 5'd0, 13'd8));
		putInstr(encodeS(5'd3, 5'd0, 12'h108));
		putInstr(haltWord);
		releaseReset();
		waitStores(2, "branch");
		checkStore("branch after taken beq", 0, 32'h104, 32'd2);
		checkStore("branch after not-taken beq", 1, 32'h108, 32'd3);
		compareWord("branch skipped store", 32'h0, mem[64]);
		endTest("branch");
	endtask

	task automatic jalTest;
		beginTest();
		putInstr(encodeI(opLogic, 3'b000, 5'd1, 5'd0, 12'd5));
		// jal at 0x4 lands on 0x10, link is 0x8
		putInstr(encodeJ(5'd6, 21'd12));
		putInstr(encodeS(5'd1, 5'd0, 12'h100));
		putInstr(encodeS(5'd1, 5'd0, 12'h104));
		putInstr(encodeS(5'd6, 5'd0, 12'h108));
		putInstr(haltWord);
		releaseReset();
		waitStores(1, "jal");
		checkStore("jal link", 0, 32'h108, 32'h8);
		compareWord("jal skipped store 0x100", 32'h0, mem[64]);
		compareWord("jal skipped store 0x104", 32'h0, mem[65]);
		endTest("jal");
	endtask

	initial begin
		seed       = 28;
		testCount  = 0;
		checkCount = 0;
		errorCount = 0;
		progIndex  = 0;
		reset      = 1'b1;
		clearMemory();
		resetTest();
		rTypeTest();
		iTypeTest();
		loadStoreTest();
		branchTest();
		jalTest();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- src/rvCore.sv
// ####################
// multicycle RV32I core top with one shared memory port
// ####################

`timescale 1ns/100ps

module rvCore #(
	parameter logic [rvPkg::xlen-1:0] resetVector = '0
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [rvPkg::xlen-1:0] memReadData,
	output logic [rvPkg::xlen-1:0] memAddr,
	output logic [rvPkg::xlen-1:0] memWriteData,
	output logic                   memWrite
);
	import rvPkg::*;

	adrSrc_t    adrSrc;
	logic       irWrite;
	logic       regWrite;
	logic       pcWrite;
	aluSrcA_t   aluSrcA;
	aluSrcB_t   aluSrcB;
	resultSrc_t resultSrc;
	aluOp_t     aluOp;
	aluCtrl_t   aluCtrl;
	opcode_t    opcode;
	logic [2:0] funct3;
	logic       funct7b5;
	logic       opcodeB5;
	logic       zero;

	controlFsm uControlFsm (
		.clk       (clk),
		.reset     (reset),
		.opcode    (opcode),
		.zero      (zero),
		.adrSrc    (adrSrc),
		.irWrite   (irWrite),
		.regWrite  (regWrite),
		.pcWrite   (pcWrite),
		.memWrite  (memWrite),
		.aluSrcA   (aluSrcA),
		.aluSrcB   (aluSrcB),
		.resultSrc (resultSrc),
		.aluOp     (aluOp)
	);

	aluDecoder uAluDecoder (
		.aluOp    (aluOp),
		.funct3   (funct3),
		.funct7b5 (funct7b5),
		.opcodeB5 (opcodeB5),
		.aluCtrl  (aluCtrl)
	);

	multicycleDatapath #(
		.resetVector (resetVector)
	) uDatapath (
		.clk          (clk),
		.reset        (reset),
		.adrSrc       (adrSrc),
		.irWrite      (irWrite),
		.regWrite     (regWrite),
		.pcWrite      (pcWrite),
		.memWrite     (memWrite),
		.aluSrcA      (aluSrcA),
		.aluSrcB      (aluSrcB),
		.resultSrc    (resultSrc),
		.aluCtrl      (aluCtrl),
		.memReadData  (memReadData),
		.opcode       (opcode),
		.funct3       (funct3),
		.funct7b5     (funct7b5),
		.opcodeB5     (opcodeB5),
		.zero         (zero),
		.memAddr      (memAddr),
		.memWriteData (memWriteData)
	);

endmodule

//--- control/aluDecoder.sv
// ####################
// ALU decoder, op class and funct bits to ALU control
// ####################

`timescale 1ns/100ps

module aluDecoder (
	input  rvPkg::aluOp_t   aluOp,
	input  logic [2:0]      funct3,
	input  logic            funct7b5,
	input  logic            opcodeB5,
	output rvPkg::aluCtrl_t aluCtrl
);
	import rvPkg::*;

	logic isSub;

	// sub only for R-type with funct7 bit 5 set, never for addi
	assign isSub = (aluOp == opFunct) && funct7b5 && opcodeB5;

	always_comb begin
		case (aluOp)
			opAdd: aluCtrl = aluAdd;
			opSub: aluCtrl = aluSub;
			default: begin
				case (funct3)
					3'b000:  aluCtrl = isSub ? aluSub : aluAdd;
					3'b010:  aluCtrl = aluSlt;
					3'b110:  aluCtrl = aluOr;
					3'b111:  aluCtrl = aluAnd;
					default: aluCtrl = aluAdd;
				endcase
			end
		endcase
	end

endmodule

//--- control/controlFsm.sv
// ####################
// Moore control FSM, steps each instruction through its states
// ####################

`timescale 1ns/100ps

module controlFsm (
	input  logic              clk,
	input  logic              reset,
	input  rvPkg::opcode_t     opcode,
	input  logic              zero,
	output rvPkg::adrSrc_t     adrSrc,
	output logic              irWrite,
	output logic              regWrite,
	output logic              pcWrite,
	output logic              memWrite,
	output rvPkg::aluSrcA_t    aluSrcA,
	output rvPkg::aluSrcB_t    aluSrcB,
	output rvPkg::resultSrc_t  resultSrc,
	output rvPkg::aluOp_t      aluOp
);
	import rvPkg::*;

	typedef enum logic [3:0] {
		stFetch,
		stDecode,
		stExecuteR,
		stExecuteI,
		stJump,
		stMemAdr,
		stMemRead,
		stMemWrite,
		stMemWb,
		stAluWb,
		stBranchEq
	} state_t;

	state_t state;
	state_t nextState;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			stFetch: nextState = stDecode;
			stDecode: begin
				// unknown opcodes park here until reset
				case (opcode)
					rType:      nextState = stExecuteR;
					iTypeLogic: nextState = stExecuteI;
					iTypeLoad:  nextState = stMemAdr;
					sType:      nextState = stMemAdr;
					bType:      nextState = stBranchEq;
					jType:      nextState = stJump;
					default:    nextState = stDecode;
				endcase
			end
			stExecuteR: nextState = stAluWb;
			stExecuteI: nextState = stAluWb;
			stJump:     nextState = stAluWb;
			stMemAdr: begin
				if (opcode == iTypeLoad) begin
					nextState = stMemRead;
				end else if (opcode == sType) begin
					nextState = stMemWrite;
				end else begin
					nextState = stMemAdr;
				end
			end
			stMemRead: nextState = stMemWb;
			default:   nextState = stFetch;
		endcase
	end

	// outputs depend on state only, apart from the branch decision
	always_comb begin
		adrSrc    = adrPc;
		irWrite   = 1'b0;
		regWrite  = 1'b0;
		pcWrite   = 1'b0;
		memWrite  = 1'b0;
		aluSrcA   = srcAPc;
		aluSrcB   = srcBRd2;
		resultSrc = resAluOut;
		aluOp     = opAdd;
		case (state)
			stFetch: begin
				// PC+4 straight from the ALU into PC
				irWrite   = 1'b1;
				pcWrite   = 1'b1;
				aluSrcB   = srcBFour;
				resultSrc = resAluResult;
			end
			stDecode: begin
				// branch/jump target parked in ALU out
				aluSrcA = srcAOldPc;
				aluSrcB = srcBImmExt;
			end
			stExecuteR: begin
				aluSrcA = srcARd1;
				aluOp   = opFunct;
			end
			stExecuteI: begin
				aluSrcA = srcARd1;
				aluSrcB = srcBImmExt;
				aluOp   = opFunctImm;
			end
			stJump: begin
				// target into PC, link address into ALU out
				aluSrcA = srcAOldPc;
				aluSrcB = srcBFour;
				pcWrite = 1'b1;
			end
			stMemAdr: begin
				aluSrcA = srcARd1;
				aluSrcB = srcBImmExt;
			end
			stMemRead: adrSrc = adrResult;
			stMemWrite: begin
				adrSrc   = adrResult;
				memWrite = 1'b1;
			end
			stMemWb: begin
				resultSrc = resMemData;
				regWrite  = 1'b1;
			end
			stAluWb: regWrite = 1'b1;
			stBranchEq: begin
				aluSrcA = srcARd1;
				aluOp   = opSub;
				pcWrite = zero;
			end
			default: ;
		endcase
	end

	assert property (@(posedge clk) disable iff (reset) !(regWrite && memWrite));

	// every instruction restarts from fetch after reset
	assert property (@(posedge clk) reset |=> (state == stFetch));

endmodule

//--- datapath/multicycleDatapath.sv
// ####################
// multicycle datapath, state registers and source muxes
// ####################

`timescale 1ns/100ps

module multicycleDatapath #(
	parameter logic [rvPkg::xlen-1:0] resetVector = '0
) (
	input  logic                   clk,
	input  logic                   reset,
	input  rvPkg::adrSrc_t         adrSrc,
	input  logic                   irWrite,
	input  logic                   regWrite,
	input  logic                   pcWrite,
	input  logic                   memWrite,
	input  rvPkg::aluSrcA_t        aluSrcA,
	input  rvPkg::aluSrcB_t        aluSrcB,
	input  rvPkg::resultSrc_t      resultSrc,
	input  rvPkg::aluCtrl_t        aluCtrl,
	input  logic [rvPkg::xlen-1:0] memReadData,
	output rvPkg::opcode_t         opcode,
	output logic [2:0]             funct3,
	output logic                   funct7b5,
	output logic                   opcodeB5,
	output logic                   zero,
	output logic [rvPkg::xlen-1:0] memAddr,
	output logic [rvPkg::xlen-1:0] memWriteData
);
	import rvPkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] oldPc;
	instr_t          instr;
	logic [xlen-1:0] aReg;
	logic [xlen-1:0] bReg;
	logic [xlen-1:0] aluOut;
	logic [xlen-1:0] memData;
	logic [xlen-1:0] rd1;
	logic [xlen-1:0] rd2;
	logic [xlen-1:0] immExt;
	logic [xlen-1:0] srcA;
	logic [xlen-1:0] srcB;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] result;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetVector;
		end else if (pcWrite) begin
			pc <= result;
		end
	end

	// old PC is captured with the instruction it belongs to
	always_ff @(posedge clk) begin
		if (irWrite) begin
			oldPc     <= pc;
			instr.raw <= memReadData;
		end
		aReg    <= rd1;
		bReg    <= rd2;
		aluOut  <= aluResult;
		memData <= memReadData;
	end

	regFile uRegFile (
		.clk (clk),
		.ra1 (instr.r.rs1),
		.ra2 (instr.r.rs2),
		.wa  (instr.r.rd),
		.we  (regWrite),
		.wd  (result),
		.rd1 (rd1),
		.rd2 (rd2)
	);

	immExtend uImmExtend (
		.instr  (instr),
		.opcode (instr.r.opcode),
		.immExt (immExt)
	);

	always_comb begin
		case (aluSrcA)
			srcAPc:    srcA = pc;
			srcAOldPc: srcA = oldPc;
			srcARd1:   srcA = aReg;
			default:   srcA = '0;
		endcase
	end

	always_comb begin
		case (aluSrcB)
			srcBRd2:    srcB = bReg;
			srcBImmExt: srcB = immExt;
			srcBFour:   srcB = xlen'(4);
			default:    srcB = '0;
		endcase
	end

	alu uAlu (
		.a       (srcA),
		.b       (srcB),
		.aluCtrl (aluCtrl),
		.result  (aluResult),
		.zero    (zero)
	);

	always_comb begin
		case (resultSrc)
			resAluOut:    result = aluOut;
			resMemData:   result = memData;
			resAluResult: result = aluResult;
			default:      result = aluOut;
		endcase
	end

	assign memAddr      = (adrSrc == adrPc) ? pc : result;
	assign memWriteData = bReg;

	// decode fields for the control path
	assign opcode   = instr.r.opcode;
	assign funct3   = instr.r.funct3;
	assign funct7b5 = instr.r.funct7[5];
	assign opcodeB5 = instr.raw[5];

	// a store goes to the computed address with the instruction held
	assert property (@(posedge clk) disable iff (reset)
		memWrite |-> (adrSrc == adrResult) && !irWrite);

endmodule

//--- datapath/alu.sv
// ####################
// 32-bit ALU with zero flag
// ####################

`timescale 1ns/100ps

module alu (
	input  logic [rvPkg::xlen-1:0] a,
	input  logic [rvPkg::xlen-1:0] b,
	input  rvPkg::aluCtrl_t        aluCtrl,
	output logic [rvPkg::xlen-1:0] result,
	output logic                   zero
);
	import rvPkg::*;

	logic lessThan;

	// signed compare for slt
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluCtrl)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluSlt:  result = {{(xlen-1){1'b0}}, lessThan};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- datapath/immExtend.sv
// ####################
// immediate extender for I, S, B and J formats
// ####################

`timescale 1ns/100ps

module immExtend (
	input  rvPkg::instr_t          instr,
	input  rvPkg::opcode_t         opcode,
	output logic [rvPkg::xlen-1:0] immExt
);
	import rvPkg::*;

	always_comb begin
		case (opcode)
			iTypeLogic, iTypeLoad: begin
				immExt = {{20{instr.i.imm[11]}}, instr.i.imm};
			end
			sType: begin
				immExt = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
			end
			bType: begin
				// imm[12|10:5] in immHi, imm[4:1|11] in immLo
				immExt = {{19{instr.s.immHi[6]}}, instr.s.immHi[6], instr.s.immLo[0],
					instr.s.immHi[5:0], instr.s.immLo[4:1], 1'b0};
			end
			jType: begin
				// J bits are scattered over funct7, rs2, rs1 and funct3
				immExt = {{11{instr.r.funct7[6]}}, instr.r.funct7[6], instr.r.rs1,
					instr.r.funct3, instr.r.rs2[0], instr.r.funct7[5:0],
					instr.r.rs2[4:1], 1'b0};
			end
			default: immExt = '0;
		endcase
	end

endmodule

//--- datapath/regFile.sv
// ####################
// register file, two reads and one write, x0 reads zero
// ####################

`timescale 1ns/100ps

module regFile (
	input  logic                  clk,
	input  logic [4:0]            ra1,
	input  logic [4:0]            ra2,
	input  logic [4:0]            wa,
	input  logic                  we,
	input  logic [rvPkg::xlen-1:0] wd,
	output logic [rvPkg::xlen-1:0] rd1,
	output logic [rvPkg::xlen-1:0] rd2
);
	import rvPkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (we && (wa != 5'd0)) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

	assert property (@(posedge clk) (ra1 == 5'd0) |-> (rd1 == '0));
	assert property (@(posedge clk) (ra2 == 5'd0) |-> (rd2 == '0));

endmodule

//--- common/rvPkg.sv
// ####################
// shared types for the multicycle RV32I core
// opcodes, mux selects, ALU codes, instruction views
// ####################

package rvPkg;

	parameter int xlen = 32;

	// base opcodes of the supported instruction classes
	typedef enum logic [6:0] {
		rType      = 7'b0110011,
		iTypeLogic = 7'b0010011,
		iTypeLoad  = 7'b0000011,
		sType      = 7'b0100011,
		bType      = 7'b1100011,
		jType      = 7'b1101111
	} opcode_t;

	// memory address source
	typedef enum logic {
		adrPc     = 1'b0,
		adrResult = 1'b1
	} adrSrc_t;

	typedef enum logic [1:0] {
		srcAPc    = 2'b00,
		srcAOldPc = 2'b01,
		srcARd1   = 2'b10
	} aluSrcA_t;

	typedef enum logic [1:0] {
		srcBRd2    = 2'b00,
		srcBImmExt = 2'b01,
		srcBFour   = 2'b10
	} aluSrcB_t;

	// aluResult bypasses the ALU-out register so fetch can load PC+4
	typedef enum logic [1:0] {
		resAluOut    = 2'b00,
		resMemData   = 2'b01,
		resAluResult = 2'b10
	} resultSrc_t;

	// operation class from the FSM
	typedef enum logic [1:0] {
		opAdd      = 2'b00,
		opSub      = 2'b01,
		opFunct    = 2'b10,
		opFunctImm = 2'b11
	} aluOp_t;

	typedef enum logic [2:0] {
		aluAdd = 3'b000,
		aluSub = 3'b001,
		aluAnd = 3'b010,
		aluOr  = 3'b011,
		aluSlt = 3'b101
	} aluCtrl_t;

	// one instruction word, seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			opcode_t    opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			opcode_t     opcode;
		} i;
		struct packed {
			logic [6:0] immHi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			opcode_t    opcode;
		} s;
		logic [31:0] raw;
	} instr_t;

endpackage
